//--- rtl/line_store_macros.svh
`ifndef LINE_STORE_MACROS_SVH
`define LINE_STORE_MACROS_SVH

// bus widths
`define LS_ADDR_W       64
`define LS_ID_W         16
`define LS_LINE_W       512     // one 64-byte line

// the tag sits above the index and the index above the offset
`define LS_OFFSET_W     6
`define LS_INDEX_W      10
`define LS_TAG_W        48
`define LS_INDEX_LSB    `LS_OFFSET_W
`define LS_TAG_LSB      (`LS_OFFSET_W + `LS_INDEX_W)

// stored tag word
`define LS_TAGWORD_W    64
`define LS_BLANK_W      14      // zero pad below the tag

`endif

//--- rtl/axi_line_pkg.sv
`include "line_store_macros.svh"

package axi_line_pkg;

    // write address
    typedef struct packed {
        logic [`LS_ID_W-1:0]        id;
        logic [`LS_ADDR_W-1:0]      addr;
    } aw_chan_t;

    // write data, one full line per beat
    typedef struct packed {
        logic [`LS_ID_W-1:0]        id;
        logic [`LS_LINE_W-1:0]      data;
    } w_chan_t;

    // write response
    typedef struct packed {
        logic [`LS_ID_W-1:0]        id;
    } b_chan_t;

    // read address
    typedef struct packed {
        logic [`LS_ID_W-1:0]        id;
        logic [`LS_ADDR_W-1:0]      addr;
    } ar_chan_t;

    // read data carries tag word and line together
    typedef struct packed {
        logic [`LS_ID_W-1:0]        id;
        logic [`LS_TAGWORD_W-1:0]   tag;    // raw tag word
        logic [`LS_LINE_W-1:0]      line;
    } r_chan_t;

endpackage

//--- rtl/line_tag_pkg.sv
`include "line_store_macros.svh"

package line_tag_pkg;

    // tag word layout, msb first
    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`LS_TAG_W-1:0]       tag;
        logic [`LS_BLANK_W-1:0]     blank;
    } tag_fields_t;

    // storage sees raw bits, logic sees the fields
    typedef union packed {
        logic [`LS_TAGWORD_W-1:0]   raw;
        tag_fields_t                fields;
    } tag_word_u;

    typedef enum logic [1:0] {
        OP_FILL  = 2'd1,
        OP_EVICT = 2'd2
    } ls_op_e;

    // request from the cache side
    typedef struct packed {
        ls_op_e                     op;
        logic [`LS_ADDR_W-1:0]      addr;
        logic [`LS_LINE_W-1:0]      line;   // only meaningful for evict
    } ls_cmd_t;

endpackage

//--- rtl/line_array.sv
`include "line_store_macros.svh"

module line_array (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we_i,
    input  logic [`LS_INDEX_W-1:0]      waddr_i,
    input  line_tag_pkg::tag_word_u     wtag_i,
    input  logic [`LS_LINE_W-1:0]       wline_i,
    input  logic [`LS_INDEX_W-1:0]      raddr_i,
    output line_tag_pkg::tag_word_u     rtag_o,
    output logic [`LS_LINE_W-1:0]       rline_o
);

    localparam int DEPTH = 1 << `LS_INDEX_W;

    logic [`LS_TAGWORD_W-1:0]   tag_mem  [DEPTH];
    logic [`LS_LINE_W-1:0]      line_mem [DEPTH];
    logic [DEPTH-1:0]           valid_q;

    // one bit per index, set by the first write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[waddr_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[waddr_i]  <= wtag_i.raw;
            line_mem[waddr_i] <= wline_i;
        end
    end

    // async read, old data on a same-index write
    assign rtag_o.raw = valid_q[raddr_i] ? tag_mem[raddr_i] : '0;
    assign rline_o    = valid_q[raddr_i] ? line_mem[raddr_i] : '0;

    a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
        we_i |-> !$isunknown(waddr_i))
        else $error("line_array write with unknown index");

endmodule

//--- rtl/line_write_fsm.sv
`include "line_store_macros.svh"

module line_write_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axi_line_pkg::aw_chan_t      aw_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  axi_line_pkg::w_chan_t       w_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    output axi_line_pkg::b_chan_t       b_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    output logic                        we_o,
    output logic [`LS_INDEX_W-1:0]      widx_o,
    output line_tag_pkg::tag_word_u     wtag_o,
    output logic [`LS_LINE_W-1:0]       wline_o
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wstate_e;

    wstate_e                    state_q, state_d;
    logic [`LS_INDEX_W-1:0]     idx_q;
    logic [`LS_ID_W-1:0]        id_q;
    line_tag_pkg::tag_word_u    tag_q, tag_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= W_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            W_IDLE: begin
                if (awvalid_i) begin
                    state_d = W_ADDR;
                end
            end
            W_ADDR: state_d = W_DATA;  // awready up for exactly one cycle
            W_DATA: begin
                if (wvalid_i) begin
                    state_d = W_RESP;
                end
            end
            W_RESP: begin
                if (bready_i) begin
                    state_d = W_IDLE;
                end
            end
            default: state_d = W_IDLE;
        endcase
    end

    // new lines go in valid and clean
    always_comb begin
        tag_d.fields.valid = 1'b1;
        tag_d.fields.dirty = 1'b0;
        tag_d.fields.tag   = aw_i.addr[`LS_ADDR_W-1:`LS_TAG_LSB];
        tag_d.fields.blank = '0;
    end

    always_ff @(posedge clk) begin
        if (state_q == W_ADDR) begin
            idx_q <= aw_i.addr[`LS_INDEX_LSB +: `LS_INDEX_W];
            tag_q <= tag_d;
            id_q  <= aw_i.id;
        end
    end

    assign awready_o = (state_q == W_ADDR);
    assign wready_o  = (state_q == W_DATA);
    assign bvalid_o  = (state_q == W_RESP);
    assign b_o.id    = id_q;    // echo of the AW id

    assign we_o    = wready_o && wvalid_i;
    assign widx_o  = idx_q;
    assign wtag_o  = tag_q;
    assign wline_o = w_i.data;

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_o && !bready_i |=> bvalid_o && $stable(b_o))
        else $error("bvalid dropped before bready");

    a_aw_w_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(awready_o && wready_o))
        else $error("awready and wready high together");

endmodule

//--- rtl/line_read_fsm.sv
`include "line_store_macros.svh"

module line_read_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axi_line_pkg::ar_chan_t      ar_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    output axi_line_pkg::r_chan_t       r_o,
    output logic                        rvalid_o,
    input  logic                        rready_i,
    output logic [`LS_INDEX_W-1:0]      ridx_o,
    input  line_tag_pkg::tag_word_u     rtag_i,
    input  logic [`LS_LINE_W-1:0]       rline_i
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_RESP
    } rstate_e;

    rstate_e                    state_q, state_d;
    logic [`LS_INDEX_W-1:0]     idx_q;
    logic [`LS_ID_W-1:0]        id_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= R_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            R_IDLE: begin
                if (arvalid_i) begin
                    state_d = R_ADDR;
                end
            end
            R_ADDR: state_d = R_RESP;
            R_RESP: begin
                if (rready_i) begin
                    state_d = R_IDLE;
                end
            end
            default: state_d = R_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state_q == R_ADDR) begin
            idx_q <= ar_i.addr[`LS_INDEX_LSB +: `LS_INDEX_W];
            id_q  <= ar_i.id;
        end
    end

    assign arready_o = (state_q == R_ADDR);
    assign rvalid_o  = (state_q == R_RESP);
    assign ridx_o    = idx_q;

    // payload straight from the array at the held index
    assign r_o.id   = id_q;
    assign r_o.tag  = rtag_i.raw;
    assign r_o.line = rline_i;

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_o && !rready_i |=> rvalid_o)
        else $error("rvalid dropped before rready");

endmodule

//--- rtl/line_store_slave.sv
`include "line_store_macros.svh"

module line_store_slave (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axi_line_pkg::aw_chan_t      aw_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  axi_line_pkg::w_chan_t       w_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    output axi_line_pkg::b_chan_t       b_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    input  axi_line_pkg::ar_chan_t      ar_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    output axi_line_pkg::r_chan_t       r_o,
    output logic                        rvalid_o,
    input  logic                        rready_i
);

    logic                       we;
    logic [`LS_INDEX_W-1:0]     widx;
    line_tag_pkg::tag_word_u    wtag;
    logic [`LS_LINE_W-1:0]      wline;
    logic [`LS_INDEX_W-1:0]     ridx;
    line_tag_pkg::tag_word_u    rtag;
    logic [`LS_LINE_W-1:0]      rline;

    //----------------------------------------------------------
    // write path (AW, W, B)
    //----------------------------------------------------------
    line_write_fsm u_write (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_i      (aw_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .w_i       (w_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .b_o       (b_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .we_o      (we),
        .widx_o    (widx),
        .wtag_o    (wtag),
        .wline_o   (wline)
    );

    //----------------------------------------------------------
    // read path (AR, R)
    //----------------------------------------------------------
    line_read_fsm u_read (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar_i      (ar_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .r_o       (r_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .ridx_o    (ridx),
        .rtag_i    (rtag),
        .rline_i   (rline)
    );

    // shared storage
    line_array u_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .we_i    (we),
        .waddr_i (widx),
        .wtag_i  (wtag),
        .wline_i (wline),
        .raddr_i (ridx),
        .rtag_o  (rtag),
        .rline_o (rline)
    );

endmodule

//--- rtl/line_refill_master.sv
`include "line_store_macros.svh"

module line_refill_master (
    input  logic                        clk,
    input  logic                        rst_n,
    input  line_tag_pkg::ls_cmd_t       cmd_i,
    input  logic                        cmd_valid_i,
    output logic                        busy_o,
    output logic                        done_o,
    output line_tag_pkg::tag_fields_t   resp_tag_o,
    output logic [`LS_LINE_W-1:0]       resp_line_o,
    output axi_line_pkg::aw_chan_t      aw_o,
    output logic                        awvalid_o,
    input  logic                        awready_i,
    output axi_line_pkg::w_chan_t       w_o,
    output logic                        wvalid_o,
    input  logic                        wready_i,
    input  axi_line_pkg::b_chan_t       b_i,
    input  logic                        bvalid_i,
    output logic                        bready_o,
    output axi_line_pkg::ar_chan_t      ar_o,
    output logic                        arvalid_o,
    input  logic                        arready_i,
    input  axi_line_pkg::r_chan_t       r_i,
    input  logic                        rvalid_i,
    output logic                        rready_o
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_AW,
        M_W,
        M_B,
        M_AR,
        M_R
    } mstate_e;

    mstate_e                    state_q, state_d;
    line_tag_pkg::ls_cmd_t      cmd_q;
    logic [`LS_ID_W-1:0]        id_q;
    logic                       rsp_rdy_q;  // bready/rready, high once out of reset
    logic                       done_q;
    logic                       b_fire, r_fire;
    line_tag_pkg::tag_word_u    ret_word;
    line_tag_pkg::tag_fields_t  resp_tag_q;
    logic [`LS_LINE_W-1:0]      resp_line_q;

    assign b_fire = (state_q == M_B) && bvalid_i && rsp_rdy_q;
    assign r_fire = (state_q == M_R) && rvalid_i && rsp_rdy_q;

    //----------------------------------------------------------
    // command sequencing
    //----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            M_IDLE: begin
                if (cmd_valid_i) begin
                    case (cmd_i.op)
                        line_tag_pkg::OP_FILL:  state_d = M_AR;
                        line_tag_pkg::OP_EVICT: state_d = M_AW;
                        default:                state_d = M_IDLE;   // unknown op dropped
                    endcase
                end
            end
            M_AW: begin
                if (awready_i) begin
                    state_d = M_W;
                end
            end
            M_W: begin
                if (wready_i) begin
                    state_d = M_B;
                end
            end
            M_B: begin
                if (b_fire) begin
                    state_d = M_IDLE;
                end
            end
            M_AR: begin
                if (arready_i) begin
                    state_d = M_R;
                end
            end
            M_R: begin
                if (r_fire) begin
                    state_d = M_IDLE;
                end
            end
            default: state_d = M_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= M_IDLE;
            id_q      <= '0;
            rsp_rdy_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            rsp_rdy_q <= 1'b1;
            done_q    <= b_fire || r_fire;
            if (state_q == M_IDLE && state_d != M_IDLE) begin
                id_q <= id_q + 1'b1;    // fresh id per command
            end
        end
    end

    // read tag word seen through the field view
    assign ret_word.raw = r_i.tag;

    always_ff @(posedge clk) begin
        if (state_q == M_IDLE && state_d != M_IDLE) begin
            cmd_q <= cmd_i;
        end
        if (r_fire) begin
            resp_tag_q  <= ret_word.fields;
            resp_line_q <= r_i.line;
        end
    end

    //----------------------------------------------------------
    // bus side
    //----------------------------------------------------------
    assign aw_o.id    = id_q;
    assign aw_o.addr  = cmd_q.addr;
    assign w_o.id     = id_q;
    assign w_o.data   = cmd_q.line;
    assign ar_o.id    = id_q;
    assign ar_o.addr  = cmd_q.addr;

    assign awvalid_o  = (state_q == M_AW);
    assign wvalid_o   = (state_q == M_W);
    assign arvalid_o  = (state_q == M_AR);
    assign bready_o   = rsp_rdy_q;
    assign rready_o   = rsp_rdy_q;

    assign busy_o      = (state_q != M_IDLE);
    assign done_o      = done_q;
    assign resp_tag_o  = resp_tag_q;
    assign resp_line_o = resp_line_q;

    // the store must answer with the id that went out
    a_b_id: assert property (@(posedge clk) disable iff (!rst_n)
        b_fire |-> b_i.id == id_q)
        else $error("B id %h does not match issued id %h", b_i.id, id_q);

    a_r_id: assert property (@(posedge clk) disable iff (!rst_n)
        r_fire |-> r_i.id == id_q)
        else $error("R id %h does not match issued id %h", r_i.id, id_q);

endmodule

//--- rtl/line_store_top.sv
`include "line_store_macros.svh"

module line_store_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  line_tag_pkg::ls_cmd_t       cmd_i,
    input  logic                        cmd_valid_i,
    output logic                        busy_o,
    output logic                        done_o,
    output line_tag_pkg::tag_fields_t   resp_tag_o,
    output logic [`LS_LINE_W-1:0]       resp_line_o
);

    axi_line_pkg::aw_chan_t     aw;
    axi_line_pkg::w_chan_t      w;
    axi_line_pkg::b_chan_t      b;
    axi_line_pkg::ar_chan_t     ar;
    axi_line_pkg::r_chan_t      r;
    logic                       awvalid, awready;
    logic                       wvalid, wready;
    logic                       bvalid, bready;
    logic                       arvalid, arready;
    logic                       rvalid, rready;

    line_refill_master u_master (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .resp_tag_o  (resp_tag_o),
        .resp_line_o (resp_line_o),
        .aw_o        (aw),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .w_o         (w),
        .wvalid_o    (wvalid),
        .wready_i    (wready),
        .b_i         (b),
        .bvalid_i    (bvalid),
        .bready_o    (bready),
        .ar_o        (ar),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .r_i         (r),
        .rvalid_i    (rvalid),
        .rready_o    (rready)
    );

    line_store_slave u_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_i      (aw),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .w_i       (w),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .b_o       (b),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .ar_i      (ar),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .r_o       (r),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

endmodule

//--- sim/line_store_tb.sv
`include "line_store_macros.svh"

module line_store_tb;

    localparam int RST_CYCLES  = 8;
    localparam int IDLE_CYCLES = 20;        // quiet gap after the busy strobe
    localparam int N_RAND      = 20;
    localparam int N_CMDS      = 1 + 2 + 3 + 2 * N_RAND + 3;
    localparam int WD_CYCLES   = N_CMDS * 40 + RST_CYCLES + IDLE_CYCLES + 10;

    typedef struct packed {
        logic [`LS_TAG_W-1:0]   tag;
        logic [`LS_LINE_W-1:0]  line;
    } model_entry_t;

    logic                       clk;
    logic                       rst_n;
    line_tag_pkg::ls_cmd_t      cmd;
    logic                       cmd_valid;
    logic                       busy;
    logic                       done;
    line_tag_pkg::tag_fields_t  resp_tag;
    logic [`LS_LINE_W-1:0]      resp_line;

    model_entry_t               model_mem [int];
    line_tag_pkg::tag_fields_t  exp_tag;
    logic [`LS_LINE_W-1:0]      exp_line;
    logic                       exp_fill;
    logic                       pending;    // a command is in flight
    logic                       in_reset_chk;
    int                         seed;
    int                         err_cnt;
    int                         cmd_cnt;
    int                         done_cnt;

    line_store_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .busy_o      (busy),
        .done_o      (done),
        .resp_tag_o  (resp_tag),
        .resp_line_o (resp_line)
    );

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && done) begin
            done_cnt++;
        end
    end

    //------------------------------------------------------------
    // checks
    //------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk) in_reset_chk |-> !busy && !done)
        else begin
            err_cnt++;
            $display("[ERROR] in reset busy_o = %h, done_o = %h, expected 0",
                     $sampled(busy), $sampled(done));
        end

    a_reset_exit: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !done)
        else begin
            err_cnt++;
            $display("[ERROR] after reset busy_o = %h, done_o = %h, expected 0",
                     $sampled(busy), $sampled(done));
        end

    a_fill_tag: assert property (@(posedge clk) disable iff (!rst_n)
        done && exp_fill |-> resp_tag == exp_tag)
        else begin
            err_cnt++;
            $display("[ERROR] resp_tag_o = %h, expected %h",
                     $sampled(resp_tag), $sampled(exp_tag));
        end

    a_fill_line: assert property (@(posedge clk) disable iff (!rst_n)
        done && exp_fill |-> resp_line == exp_line)
        else begin
            err_cnt++;
            $display("[ERROR] resp_line_o = %h, expected %h",
                     $sampled(resp_line), $sampled(exp_line));
        end

    // evict leaves the fill outputs alone
    a_evict_hold: assert property (@(posedge clk) disable iff (!rst_n)
        done && !exp_fill |-> $stable(resp_tag) && $stable(resp_line))
        else begin
            err_cnt++;
            $display("[ERROR] on evict resp_tag_o = %h, resp_line_o = %h, expected unchanged",
                     $sampled(resp_tag), $sampled(resp_line));
        end

    a_done_pending: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> pending)
        else begin
            err_cnt++;
            $display("done_o pulsed with no command outstanding");
        end

    //------------------------------------------------------------
    // stimulus helpers
    //------------------------------------------------------------
    function automatic logic [`LS_LINE_W-1:0] random_line();
        logic [`LS_LINE_W-1:0] l;
        for (int i = 0; i < `LS_LINE_W / 32; i++) begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // called right after a falling edge
    task automatic send_cmd(input line_tag_pkg::ls_op_e op, input logic [63:0] addr,
                            input logic [`LS_LINE_W-1:0] line);
        cmd.op    = op;
        cmd.addr  = addr;
        cmd.line  = line;
        cmd_valid = 1'b1;
        pending   = 1'b1;
        cmd_cnt++;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_done();
        while (!done) @(negedge clk);
        @(negedge clk);
        pending = 1'b0;
    endtask

    task automatic evict_line(input logic [63:0] addr, input logic [`LS_LINE_W-1:0] line);
        int idx;
        idx = addr[`LS_INDEX_LSB +: `LS_INDEX_W];
        exp_fill = 1'b0;
        send_cmd(line_tag_pkg::OP_EVICT, addr, line);
        wait_done();
        model_mem[idx] = '{tag: addr[`LS_ADDR_W-1:`LS_TAG_LSB], line: line};
    endtask

    task automatic fill_line(input logic [63:0] addr);
        int idx;
        idx      = addr[`LS_INDEX_LSB +: `LS_INDEX_W];
        exp_tag  = '0;      // unwritten index reads as all zeros
        exp_line = '0;
        if (model_mem.exists(idx)) begin
            exp_tag.valid = 1'b1;
            exp_tag.tag   = model_mem[idx].tag;
            exp_line      = model_mem[idx].line;
        end
        exp_fill = 1'b1;
        send_cmd(line_tag_pkg::OP_FILL, addr, '0);
        wait_done();
    endtask

    //------------------------------------------------------------
    // test sequence
    //------------------------------------------------------------
    initial begin
        logic [63:0]            addr;
        logic [`LS_LINE_W-1:0]  evict_data;
        logic [63:0]            rnd_addr [N_RAND];
        int                     order [N_RAND];
        bit                     used [int];
        int                     idx;
        int                     j;
        int                     tmp;

        clk = 1'b0;
        rst_n = 1'b0;
        cmd = '0;
        cmd_valid = 1'b0;
        exp_fill = 1'b0;
        exp_tag = '0;
        exp_line = '0;
        pending = 1'b0;
        in_reset_chk = 1'b0;
        seed = 71652;
        err_cnt = 0;
        cmd_cnt = 0;
        done_cnt = 0;

        @(negedge clk);
        in_reset_chk = 1'b1;
        repeat (RST_CYCLES - 1) @(negedge clk);
        in_reset_chk = 1'b0;
        rst_n = 1'b1;
        @(negedge clk);

        fill_line(64'h0000_1234_5678_0fc0);                 // never written

        addr = 64'hdead_beef_cafe_0440;
        evict_line(addr, random_line());
        fill_line(addr);

        evict_line(64'h1111_2222_3333_0880, random_line());
        evict_line(64'h4444_5555_6666_0885, random_line());   // same index, new tag
        fill_line(64'h4444_5555_6666_0880);

        // distinct random indices, filled back in shuffled order
        for (int i = 0; i < N_RAND; i++) begin
            idx = $unsigned($random(seed)) % (1 << `LS_INDEX_W);
            while (used.exists(idx)) idx = $unsigned($random(seed)) % (1 << `LS_INDEX_W);
            used[idx] = 1'b1;
            addr = {$random(seed), $random(seed)};
            addr[`LS_INDEX_LSB +: `LS_INDEX_W] = idx;
            rnd_addr[i] = addr;
            order[i] = i;
            evict_line(addr, random_line());
        end
        for (int i = N_RAND - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < N_RAND; i++) begin
            fill_line(rnd_addr[order[i]]);
        end

        // strobe a second evict while the first is still running
        addr = 64'h0bad_f00d_0000_2a40;
        exp_fill = 1'b0;
        evict_data = random_line();
        send_cmd(line_tag_pkg::OP_EVICT, addr, evict_data);
        while (!busy) @(negedge clk);
        cmd.addr  = 64'h7777_8888_9999_3e00;
        cmd.line  = random_line();
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        wait_done();
        idx = addr[`LS_INDEX_LSB +: `LS_INDEX_W];
        model_mem[idx] = '{tag: addr[`LS_ADDR_W-1:`LS_TAG_LSB], line: evict_data};
        repeat (IDLE_CYCLES) @(negedge clk);                 // stray done would show here
        fill_line(addr);
        fill_line(64'h7777_8888_9999_3e00);

        repeat (5) @(negedge clk);
        assert (done_cnt == cmd_cnt)
            else begin
                err_cnt++;
                $display("[ERROR] done pulses = %h, expected %h", done_cnt, cmd_cnt);
            end
        $display("errors: %0d  commands: %0d  done pulses: %0d", err_cnt, cmd_cnt, done_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WD_CYCLES);
        $display("errors: %0d  commands: %0d  done pulses: %0d", err_cnt, cmd_cnt, done_cnt);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- line_store_top.f
+incdir+rtl
rtl/axi_line_pkg.sv
rtl/line_tag_pkg.sv
rtl/line_array.sv
rtl/line_write_fsm.sv
rtl/line_read_fsm.sv
rtl/line_store_slave.sv
rtl/line_refill_master.sv
rtl/line_store_top.sv
sim/line_store_tb.sv
